// File: build.f
verilog/rvPkg.sv
verilog/decodeIf.sv
verilog/immDecode.sv
verilog/intExecute.sv
verilog/branchUnit.sv
verilog/loadStoreUnit.sv
verilog/execStage.sv
verification/tbClock.sv
verification/execStage_props.sv
verification/execStageTb.sv

// File: verification/execStageTb.sv
`timescale 1ns/1ps

module execStageTb;

    localparam int XLEN = rvPkg::XLEN;
    localparam int N_RAND = 40;
    localparam logic [XLEN-1:0] PC0 = 64'h1000;
    localparam logic [XLEN-1:0] NEG1 = '1;
    localparam logic [XLEN-1:0] MINNEG = 64'h8000_0000_0000_0000;

    logic            clk;
    logic            rst;
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            wen;
    logic [4:0]      rwaddr;
    logic [XLEN-1:0] wdata;
    logic            jump;
    logic [XLEN-1:0] newPc;

    string           tName[$];
    bit              tValid[$];
    bit              tWen[$];
    bit              tJump[$];
    logic [31:0]     tInst[$];
    logic [4:0]      tRd[$];
    logic [XLEN-1:0] tPc[$];
    logic [XLEN-1:0] tRs1[$];
    logic [XLEN-1:0] tRs2[$];
    logic [XLEN-1:0] tData[$];
    logic [XLEN-1:0] tNewPc[$];
    logic [7:0]      model [0:2047];  // byte image of the data memory

    integer seed;
    int     cycles = 0;
    int     limit = 0;
    int     passCount = 0;
    int     failCount = 0;
    bit     testOk;

    tbClock clkGen0 (
        .clk (clk),
        .rst (rst)
    );

    execStage #(
        .MEM_WORDS (256)
    ) dut0 (
        .clk    (clk),
        .rst    (rst),
        .valid  (valid),
        .pc     (pc),
        .inst   (inst),
        .rs1    (rs1),
        .rs2    (rs2),
        .wen    (wen),
        .rwaddr (rwaddr),
        .wdata  (wdata),
        .jump   (jump),
        .newPc  (newPc)
    );

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, 5'd2, 5'd1, f3, rd, op};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {imm, 5'd1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // f3[1:0] gives the size and f3[2] selects zero extension
    function automatic logic [XLEN-1:0] modelLoad(input logic [XLEN-1:0] addr,
                                                  input logic [2:0] f3);
        int              n;
        int              k;
        logic [XLEN-1:0] val;
        n = 1 << f3[1:0];
        val = '0;
        for (k = 0; k < n; k++) begin
            val[8*k +: 8] = model[11'(addr + k)];
        end
        if (!f3[2] && n < 8 && val[8*n-1]) begin
            val = val | (NEG1 << (8 * n));
        end
        return val;
    endfunction

    task automatic addEntry(input string name, input bit v, input logic [XLEN-1:0] p,
                            input logic [31:0] i, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input bit w, input logic [4:0] rd,
                            input logic [XLEN-1:0] d, input bit j,
                            input logic [XLEN-1:0] np);
        tName.push_back(name);
        tValid.push_back(v);
        tPc.push_back(p);
        tInst.push_back(i);
        tRs1.push_back(a);
        tRs2.push_back(b);
        tWen.push_back(w);
        tRd.push_back(rd);
        tData.push_back(d);
        tJump.push_back(j);
        tNewPc.push_back(np);
    endtask

    task automatic addWrite(input string name, input logic [31:0] i, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input logic [4:0] rd,
                            input logic [XLEN-1:0] d);
        addEntry(name, 1'b1, PC0, i, a, b, 1'b1, rd, d, 1'b0, '0);
    endtask

    task automatic addBranch(input string name, input logic [31:0] i,
                             input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                             input logic [XLEN-1:0] np);
        addEntry(name, 1'b1, PC0, i, a, b, 1'b0, 5'd0, '0, np != '0, np);
    endtask

    task automatic addStore(input string name, input bit v, input logic [2:0] f3,
                            input logic [11:0] off, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        int k;
        addEntry(name, v, PC0, sType(off, f3), a, b, 1'b0, 5'd0, '0, 1'b0, '0);
        if (v) begin
            for (k = 0; k < (1 << f3); k++) begin
                model[11'(a + off + k)] = b[8*k +: 8];
            end
        end
    endtask

    task automatic addLoad(input string name, input logic [2:0] f3, input logic [11:0] off,
                           input logic [XLEN-1:0] a, input logic [4:0] rd);
        addWrite(name, iType(off, f3, rd, rvPkg::opLoad), a, '0, rd, modelLoad(a + off, f3));
    endtask

    task automatic checkValue(input string name, input string what,
                              input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s %s: expected %h, actual %h", name, what, expected, actual);
            testOk = 1'b0;
        end
    endtask

    task automatic finishTest(input string name);
        if (testOk) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("test %-12s %s", name, testOk ? "ok" : "failed");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] d;
        logic [31:0]     sum32;
        logic [31:0]     i;
        logic [2:0]      sel;
        valid = 1'b0;
        pc    = '0;
        inst  = '0;
        rs1   = '0;
        rs2   = '0;
        seed  = 32'h725038eb;

        addEntry("idle_addi", 0, PC0, iType(12'h001, 0, 5, rvPkg::opImm), 1, 0, 0, 0, 0, 0, 0);
        addEntry("idle_jal", 0, PC0, jType(21'h100, 1), 0, 0, 0, 0, 0, 0, 0);
        addWrite("addi", iType(12'hfff, 0, 5, rvPkg::opImm), 10, 0, 5, 9);
        addWrite("srai_neg", iType(12'h404, 5, 6, rvPkg::opImm), 64'hf000_0000_0000_0010, 0, 6,
                 64'hff00_0000_0000_0001);
        addWrite("sraw_neg", rType(7'h20, 5, 7, rvPkg::opReg32), 64'h8000_0000, 64'h24, 7,
                 64'hffff_ffff_f800_0000);
        addWrite("sltiu", iType(12'hfff, 3, 8, rvPkg::opImm), 5, 0, 8, 1);
        addWrite("div_zero", rType(7'h01, 4, 9, rvPkg::opReg), 7, 0, 9, NEG1);
        addWrite("rem_zero", rType(7'h01, 6, 10, rvPkg::opReg), 7, 0, 10, 7);
        addWrite("div_ovf", rType(7'h01, 4, 11, rvPkg::opReg), MINNEG, NEG1, 11, MINNEG);
        addWrite("rem_ovf", rType(7'h01, 6, 12, rvPkg::opReg), MINNEG, NEG1, 12, 0);
        addWrite("addiw_ovf", iType(12'h001, 0, 13, rvPkg::opImm32), 64'h7fff_ffff, 0, 13,
                 64'hffff_ffff_8000_0000);
        addEntry("addi_x0", 1, PC0, iType(12'h005, 0, 0, rvPkg::opImm), 1, 0, 0, 0, 0, 0, 0);
        addWrite("mulw", rType(7'h01, 0, 14, rvPkg::opReg32), 64'h1_0001, 64'hffff, 14, NEG1);
        addWrite("divuw", rType(7'h01, 5, 15, rvPkg::opReg32), 64'hffff_ffff_ffff_fff0, 2, 15,
                 64'h7fff_fff8);
        addWrite("sub", rType(7'h20, 0, 16, rvPkg::opReg), 5, 7, 16, 64'hffff_ffff_ffff_fffe);
        addWrite("slt", rType(7'h00, 2, 17, rvPkg::opReg), NEG1, 1, 17, 1);
        addWrite("lui", {20'h80000, 5'd18, rvPkg::opLui}, 0, 0, 18, 64'hffff_ffff_8000_0000);
        addWrite("auipc", {20'h00001, 5'd19, rvPkg::opAuipc}, 0, 0, 19, 64'h2000);
        addEntry("jal", 1, PC0, jType(21'h100, 1), 0, 0, 1, 1, 64'h1004, 1, 64'h1100);
        addEntry("jal_back", 1, PC0, jType(21'h1ffff0, 2), 0, 0, 1, 2, 64'h1004, 1, 64'h0ff0);
        addEntry("jalr_odd", 1, PC0, iType(12'h004, 0, 3, rvPkg::opJalr), 64'h2001, 0, 1, 3,
                 64'h1004, 1, 64'h2004);  // sum 0x2005
        addBranch("beq_t", bType(13'h040, 0), 3, 3, 64'h1040);
        addBranch("beq_n", bType(13'h040, 0), NEG1, 1, 0);
        addBranch("bne_t", bType(13'h040, 1), NEG1, 1, 64'h1040);
        addBranch("bne_n", bType(13'h040, 1), 3, 3, 0);
        addBranch("blt_t", bType(13'h040, 4), NEG1, 1, 64'h1040);
        addBranch("blt_n", bType(13'h040, 4), 1, NEG1, 0);
        addBranch("bge_t", bType(13'h040, 5), 1, NEG1, 64'h1040);
        addBranch("bge_n", bType(13'h040, 5), NEG1, 1, 0);
        addBranch("bltu_t", bType(13'h040, 6), 1, NEG1, 64'h1040);
        addBranch("bltu_n", bType(13'h040, 6), NEG1, 1, 0);
        addBranch("bgeu_t", bType(13'h1ff8, 7), NEG1, 1, 64'h0ff8);
        addBranch("bgeu_n", bType(13'h040, 7), 1, NEG1, 0);
        addStore("sd_base", 1, 3, 12'h000, 64'h100, 64'h1122_3344_5566_7788);
        addStore("sb_off1", 1, 0, 12'h001, 64'h100, 64'hab);
        addStore("sh_off2", 1, 1, 12'h002, 64'h100, 64'hcdef);
        addStore("sw_off4", 1, 2, 12'h004, 64'h100, 64'hf0e1_d2c3);
        addStore("sd_idle", 0, 3, 12'h000, 64'h100, 64'hdead_beef_dead_beef);
        addLoad("ld", 3, 12'h000, 64'h100, 20);
        addLoad("lb", 0, 12'h001, 64'h100, 21);
        addLoad("lbu", 4, 12'h001, 64'h100, 22);
        addLoad("lh", 1, 12'h002, 64'h100, 23);
        addLoad("lhu", 5, 12'h002, 64'h100, 24);
        addLoad("lw", 2, 12'h004, 64'h100, 25);
        addLoad("lwu", 6, 12'h004, 64'h100, 26);
        addLoad("lw_low", 2, 12'h000, 64'h100, 27);

        for (int r = 0; r < N_RAND; r++) begin
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)};
            sel = $random(seed) & 7;
            sum32 = a[31:0] + b[31:0];
            case (sel)
                3'd0: begin
                    i = rType(7'h00, 0, 1, rvPkg::opReg);
                    d = a + b;
                end
                3'd1: begin
                    i = rType(7'h20, 0, 1, rvPkg::opReg);
                    d = a - b;
                end
                3'd2: begin
                    i = rType(7'h00, 4, 1, rvPkg::opReg);
                    d = a ^ b;
                end
                3'd3: begin
                    i = rType(7'h00, 7, 1, rvPkg::opReg);
                    d = a & b;
                end
                3'd4: begin
                    i = rType(7'h00, 6, 1, rvPkg::opReg);
                    d = a | b;
                end
                3'd5: begin
                    i = rType(7'h00, 3, 1, rvPkg::opReg);
                    d = {63'b0, a < b};
                end
                3'd6: begin
                    i = rType(7'h00, 0, 1, rvPkg::opReg32);
                    d = {{32{sum32[31]}}, sum32};
                end
                default: begin
                    i = rType(7'h01, 0, 1, rvPkg::opReg);
                    d = a * b;
                end
            endcase
            addWrite($sformatf("rand_%0d", r), i, a, b, 1, d);
        end
        limit = 2 * tName.size() + 20;

        @(negedge clk);  // still in reset
        valid = 1'b1;
        pc    = PC0;
        inst  = jType(21'h100, 1);
        #1;
        testOk = 1'b1;
        checkValue("reset_jal", "wen", 0, wen);
        checkValue("reset_jal", "jump", 0, jump);
        finishTest("reset_jal");
        wait (!rst);

        for (int e = 0; e < tName.size(); e++) begin
            @(negedge clk);
            valid = tValid[e];
            pc    = tPc[e];
            inst  = tInst[e];
            rs1   = tRs1[e];
            rs2   = tRs2[e];
            #1;  // just before the rising edge
            testOk = 1'b1;
            checkValue(tName[e], "wen", tWen[e], wen);
            if (tWen[e]) begin
                checkValue(tName[e], "rwaddr", tRd[e], rwaddr);
                checkValue(tName[e], "wdata", tData[e], wdata);
            end
            checkValue(tName[e], "jump", tJump[e], jump);
            checkValue(tName[e], "newPc", tNewPc[e], newPc);
            finishTest(tName[e]);
        end

        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verification/execStage_props.sv
`timescale 1ns/1ps

module execStageProps (
    input logic                   clk,
    input logic                   rst,
    input logic                   valid,
    input logic [31:0]            inst,
    input logic                   wen,
    input logic                   jump,
    input logic [rvPkg::XLEN-1:0] newPc
);

    logic noWriteOp;

    assign noWriteOp = (inst[6:0] == rvPkg::opStore) || (inst[6:0] == rvPkg::opBranch);

    idleQuiet: assert property (@(posedge clk) (!valid || rst) |-> (!wen && !jump))
        else $error("wen or jump high while idle or in reset");

    targetAligned: assert property (@(posedge clk) jump |-> !newPc[0])
        else $error("jump target has bit zero set");

    noStoreWrite: assert property (@(posedge clk) noWriteOp |-> !wen)
        else $error("store or branch raised wen");

    pcZeroIdle: assert property (@(posedge clk) !jump |-> (newPc == '0))
        else $error("newPc nonzero without jump");

endmodule

bind execStage execStageProps props0 (
    .clk   (clk),
    .rst   (rst),
    .valid (valid),
    .inst  (inst),
    .wen   (wen),
    .jump  (jump),
    .newPc (newPc)
);

// File: verification/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
    parameter real PERIOD       = 4.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;  // released on a rising edge
    end

endmodule

// File: verilog/branchUnit.sv
`timescale 1ns/1ps

module branchUnit (
    decodeIf.sink                  dec,
    input  logic [rvPkg::XLEN-1:0] pc,
    input  logic [rvPkg::XLEN-1:0] rs1,
    input  logic [rvPkg::XLEN-1:0] rs2,
    input  logic                   valid,
    input  logic                   rst,
    output logic                   jump,
    output logic [rvPkg::XLEN-1:0] newPc
);

    localparam int XLEN = rvPkg::XLEN;

    logic            taken;
    logic            isJump;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] jalrSum;

    assign jalrSum = rs1 + dec.immI;

    always_comb begin
        case (rvPkg::branchFunctT'(dec.funct3))
            rvPkg::beq:  taken = (rs1 == rs2);
            rvPkg::bne:  taken = (rs1 != rs2);
            rvPkg::blt:  taken = ($signed(rs1) < $signed(rs2));
            rvPkg::bge:  taken = ($signed(rs1) >= $signed(rs2));
            rvPkg::bltu: taken = (rs1 < rs2);
            rvPkg::bgeu: taken = (rs1 >= rs2);
            default:     taken = 1'b0;
        endcase
    end

    always_comb begin
        isJump = 1'b0;
        target = '0;
        case (dec.opcode)
            rvPkg::opBranch: begin
                isJump = taken;
                target = pc + dec.immB;
            end
            rvPkg::opJal: begin
                isJump = 1'b1;
                target = pc + dec.immJ;
            end
            rvPkg::opJalr: begin
                isJump = (dec.funct3 == 3'd0);
                target = {jalrSum[XLEN-1:1], 1'b0};  // lsb cleared
            end
            default: isJump = 1'b0;
        endcase
    end

    assign jump  = isJump && valid && !rst;
    assign newPc = jump ? target : '0;

endmodule

// File: verilog/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf;

    rvPkg::opcodeT           opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [4:0]              rd;
    logic [rvPkg::XLEN-1:0]  immI;
    logic [rvPkg::XLEN-1:0]  immS;
    logic [rvPkg::XLEN-1:0]  immB;
    logic [rvPkg::XLEN-1:0]  immU;
    logic [rvPkg::XLEN-1:0]  immJ;

    modport source (
        output opcode,
        output funct3,
        output funct7,
        output rd,
        output immI,
        output immS,
        output immB,
        output immU,
        output immJ
    );

    modport sink (
        input opcode,
        input funct3,
        input funct7,
        input rd,
        input immI,
        input immS,
        input immB,
        input immU,
        input immJ
    );

endinterface

// File: verilog/execStage.sv
`timescale 1ns/1ps

module execStage #(
    parameter int MEM_WORDS = 256
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid,
    input  logic [rvPkg::XLEN-1:0] pc,
    input  logic [31:0]            inst,
    input  logic [rvPkg::XLEN-1:0] rs1,
    input  logic [rvPkg::XLEN-1:0] rs2,
    output logic                   wen,
    output logic [4:0]             rwaddr,
    output logic [rvPkg::XLEN-1:0] wdata,
    output logic                   jump,
    output logic [rvPkg::XLEN-1:0] newPc
);

    logic [rvPkg::XLEN-1:0] loadValue;

    decodeIf dec ();

    immDecode decoder0 (
        .inst (inst),
        .dec  (dec.source)
    );

    intExecute exec0 (
        .dec       (dec.sink),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .loadValue (loadValue),
        .valid     (valid),
        .rst       (rst),
        .wen       (wen),
        .rwaddr    (rwaddr),
        .wdata     (wdata)
    );

    branchUnit branch0 (
        .dec   (dec.sink),
        .pc    (pc),
        .rs1   (rs1),
        .rs2   (rs2),
        .valid (valid),
        .rst   (rst),
        .jump  (jump),
        .newPc (newPc)
    );

    loadStoreUnit #(
        .MEM_WORDS (MEM_WORDS)
    ) lsu0 (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .dec       (dec.sink),
        .rs1       (rs1),
        .rs2       (rs2),
        .loadValue (loadValue)  // already extended
    );

endmodule

// File: verilog/immDecode.sv
`timescale 1ns/1ps

module immDecode (
    input  logic [31:0] inst,
    decodeIf.source     dec
);

    localparam int XLEN = rvPkg::XLEN;

    logic [31:0] rawI;
    logic [31:0] rawS;
    logic [31:0] rawB;
    logic [31:0] rawU;
    logic [31:0] rawJ;

    // raw holds a field right-aligned, bits gives its width
    function automatic logic [XLEN-1:0] signExtend(
        input logic [31:0] raw,
        input int          bits
    );
        logic [XLEN-1:0] aligned;
        aligned = {{(XLEN-32){1'b0}}, raw} << (XLEN - bits);
        return $signed(aligned) >>> (XLEN - bits);
    endfunction

    assign dec.opcode = rvPkg::opcodeT'(inst[6:0]);
    assign dec.funct3 = inst[14:12];
    assign dec.funct7 = inst[31:25];
    assign dec.rd     = inst[11:7];

    assign rawI = {20'b0, inst[31:20]};
    assign rawS = {20'b0, inst[31:25], inst[11:7]};
    assign rawB = {19'b0, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign rawU = {inst[31:12], 12'b0};
    assign rawJ = {11'b0, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign dec.immI = signExtend(rawI, 12);
    assign dec.immS = signExtend(rawS, 12);
    assign dec.immB = signExtend(rawB, 13);
    assign dec.immU = signExtend(rawU, 32);
    assign dec.immJ = signExtend(rawJ, 21);

endmodule

// File: verilog/intExecute.sv
`timescale 1ns/1ps

module intExecute (
    decodeIf.sink                  dec,
    input  logic [rvPkg::XLEN-1:0] pc,
    input  logic [rvPkg::XLEN-1:0] rs1,
    input  logic [rvPkg::XLEN-1:0] rs2,
    input  logic [rvPkg::XLEN-1:0] loadValue,
    input  logic                   valid,
    input  logic                   rst,
    output logic                   wen,
    output logic [4:0]             rwaddr,
    output logic [rvPkg::XLEN-1:0] wdata
);

    localparam int XLEN = rvPkg::XLEN;

    logic            isImm;
    logic            isWord;
    logic            isMulDiv;
    logic            isSub;
    logic            zeroExt;
    logic            wordOp;
    logic            mdLegal;
    logic            aluLegal;
    logic            wbLegal;
    logic [6:0]      funct6;
    logic [5:0]      shamt;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluOut;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] result;

    function automatic logic [XLEN-1:0] mulDiv(
        input logic [2:0]      funct3,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic            divZero;
        logic            overflow;
        logic [XLEN-1:0] sQuot;
        logic [XLEN-1:0] sRem;
        logic [XLEN-1:0] uQuot;
        logic [XLEN-1:0] uRem;
        logic [XLEN-1:0] res;
        divZero  = (b == '0);
        overflow = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
        sQuot    = $signed(a) / $signed(b);
        sRem     = $signed(a) % $signed(b);
        uQuot    = a / b;
        uRem     = a % b;
        case (rvPkg::muldivFunctT'(funct3))
            rvPkg::mul:  res = a * b;
            rvPkg::div:  res = divZero ? '1 : (overflow ? a : sQuot);
            rvPkg::divu: res = divZero ? '1 : uQuot;
            rvPkg::rem:  res = divZero ? a : (overflow ? '0 : sRem);
            rvPkg::remu: res = divZero ? a : uRem;
            default:     res = '0;
        endcase
        return res;
    endfunction

    assign isImm    = (dec.opcode == rvPkg::opImm) || (dec.opcode == rvPkg::opImm32);
    assign isWord   = (dec.opcode == rvPkg::opImm32) || (dec.opcode == rvPkg::opReg32);
    assign isMulDiv = !isImm && (dec.funct7 == rvPkg::FUNCT7_MULDIV);
    assign isSub    = !isImm && (dec.funct7 == rvPkg::FUNCT7_ALT);
    assign funct6   = {dec.funct7[6:1], 1'b0};  // rv64 shamt[5] sits in funct7[0]
    assign mdLegal  = (dec.funct3 == rvPkg::mul) || dec.funct3[2];
    assign wordOp   = (dec.funct3 == rvPkg::aluAdd) || (dec.funct3 == rvPkg::aluSll)
                   || (dec.funct3 == rvPkg::aluSrl);

    // srlw, divuw and remuw see zero-extended operands
    assign zeroExt  = ((dec.funct3 == rvPkg::aluSrl) && !dec.funct7[5])
                   || (isMulDiv && (dec.funct3 == rvPkg::remu));

    assign srcB  = isImm ? dec.immI : rs2;
    assign shamt = isWord ? {1'b0, srcB[4:0]} : srcB[5:0];

    always_comb begin
        opA = rs1;
        opB = srcB;
        if (isWord && zeroExt) begin
            opA = {{(XLEN-32){1'b0}}, rs1[31:0]};
            opB = {{(XLEN-32){1'b0}}, srcB[31:0]};
        end else if (isWord) begin
            opA = {{(XLEN-32){rs1[31]}}, rs1[31:0]};
            opB = {{(XLEN-32){srcB[31]}}, srcB[31:0]};
        end
    end

    always_comb begin
        aluOut = '0;
        if (isMulDiv) begin
            aluOut = mulDiv(dec.funct3, opA, opB);
        end else begin
            case (rvPkg::aluFunctT'(dec.funct3))
                rvPkg::aluAdd:  aluOut = isSub ? opA - opB : opA + opB;
                rvPkg::aluSll:  aluOut = opA << shamt;
                rvPkg::aluSlt:  aluOut = XLEN'($signed(opA) < $signed(opB));
                rvPkg::aluSltu: aluOut = XLEN'(opA < opB);
                rvPkg::aluXor:  aluOut = opA ^ opB;
                rvPkg::aluOr:   aluOut = opA | opB;
                rvPkg::aluAnd:  aluOut = opA & opB;
                rvPkg::aluSrl: begin
                    if (dec.funct7[5]) begin
                        aluOut = $signed(opA) >>> shamt;
                    end else begin
                        aluOut = opA >> shamt;
                    end
                end
                default: aluOut = '0;
            endcase
        end
    end

    assign aluResult = isWord ? {{(XLEN-32){aluOut[31]}}, aluOut[31:0]} : aluOut;

    always_comb begin
        aluLegal = 1'b0;
        case (dec.opcode)
            rvPkg::opImm: begin
                if (dec.funct3 == rvPkg::aluSll) begin
                    aluLegal = (funct6 == 7'b0);
                end else if (dec.funct3 == rvPkg::aluSrl) begin
                    aluLegal = (funct6 == 7'b0) || (funct6 == rvPkg::FUNCT7_ALT);
                end else begin
                    aluLegal = 1'b1;
                end
            end
            rvPkg::opImm32: begin
                aluLegal = (dec.funct3 == rvPkg::aluAdd)
                        || (wordOp && (dec.funct7 == 7'b0))
                        || ((dec.funct3 == rvPkg::aluSrl) && (dec.funct7 == rvPkg::FUNCT7_ALT));
            end
            rvPkg::opReg, rvPkg::opReg32: begin
                if (isMulDiv) begin
                    aluLegal = mdLegal;
                end else if (dec.funct7 == 7'b0) begin
                    aluLegal = !isWord || wordOp;
                end else if (isSub) begin
                    aluLegal = (dec.funct3 == rvPkg::aluAdd) || (dec.funct3 == rvPkg::aluSrl);
                end
            end
            default: aluLegal = 1'b0;
        endcase
    end

    always_comb begin
        wbLegal = 1'b0;
        result  = '0;
        case (dec.opcode)
            rvPkg::opLui: begin
                wbLegal = 1'b1;
                result  = dec.immU;
            end
            rvPkg::opAuipc: begin
                wbLegal = 1'b1;
                result  = pc + dec.immU;
            end
            rvPkg::opJal, rvPkg::opJalr: begin
                wbLegal = (dec.opcode == rvPkg::opJal) || (dec.funct3 == 3'd0);
                result  = pc + XLEN'(4);  // link address
            end
            rvPkg::opLoad: begin
                wbLegal = (dec.funct3 != 3'd7);
                result  = loadValue;
            end
            rvPkg::opImm, rvPkg::opImm32, rvPkg::opReg, rvPkg::opReg32: begin
                wbLegal = aluLegal;
                result  = aluResult;
            end
            default: wbLegal = 1'b0;
        endcase
    end

    assign wen    = wbLegal && (dec.rd != 5'd0) && valid && !rst;
    assign rwaddr = dec.rd;
    assign wdata  = result;

endmodule

// File: verilog/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit #(
    parameter int MEM_WORDS = 256
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid,
    decodeIf.sink                  dec,
    input  logic [rvPkg::XLEN-1:0] rs1,
    input  logic [rvPkg::XLEN-1:0] rs2,
    output logic [rvPkg::XLEN-1:0] loadValue
);

    localparam int XLEN  = rvPkg::XLEN;
    localparam int BYTES = XLEN / 8;
    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic             isStore;
    logic             storeEn;
    logic [XLEN-1:0]  addr;
    logic [IDX_W-1:0] wordIdx;
    logic [2:0]       offset;
    logic [BYTES-1:0] widthMask;
    logic [BYTES-1:0] byteMask;
    logic [XLEN-1:0]  storeData;
    logic [XLEN-1:0]  rawWord;

    assign isStore = (dec.opcode == rvPkg::opStore);
    assign storeEn = isStore && valid && !rst;
    assign addr    = rs1 + (isStore ? dec.immS : dec.immI);
    assign wordIdx = addr[IDX_W+2:3];  // wraps, depth is a power of two
    assign offset  = addr[2:0];

    always_comb begin
        case (rvPkg::storeFunctT'(dec.funct3))
            rvPkg::sb: widthMask = BYTES'(8'h01);
            rvPkg::sh: widthMask = BYTES'(8'h03);
            rvPkg::sw: widthMask = BYTES'(8'h0f);
            rvPkg::sd: widthMask = '1;
            default:   widthMask = '0;
        endcase
    end

    assign byteMask  = widthMask << offset;
    assign storeData = rs2 << {offset, 3'b000};

    always_ff @(posedge clk) begin
        if (storeEn) begin
            for (int b = 0; b < BYTES; b++) begin
                if (byteMask[b]) begin
                    mem[wordIdx][8*b +: 8] <= storeData[8*b +: 8];
                end
            end
        end
    end

    // addressed byte lands in bits 7:0
    assign rawWord = mem[wordIdx] >> {offset, 3'b000};

    always_comb begin
        case (rvPkg::loadFunctT'(dec.funct3))
            rvPkg::lb:  loadValue = {{(XLEN-8){rawWord[7]}}, rawWord[7:0]};
            rvPkg::lh:  loadValue = {{(XLEN-16){rawWord[15]}}, rawWord[15:0]};
            rvPkg::lw:  loadValue = {{(XLEN-32){rawWord[31]}}, rawWord[31:0]};
            rvPkg::ld:  loadValue = rawWord;
            rvPkg::lbu: loadValue = {{(XLEN-8){1'b0}}, rawWord[7:0]};
            rvPkg::lhu: loadValue = {{(XLEN-16){1'b0}}, rawWord[15:0]};
            rvPkg::lwu: loadValue = {{(XLEN-32){1'b0}}, rawWord[31:0]};
            default:    loadValue = '0;
        endcase
    end

endmodule

// File: verilog/rvPkg.sv
package rvPkg;

    localparam int XLEN = 64;

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opImm    = 7'b0010011,
        opImm32  = 7'b0011011,
        opReg    = 7'b0110011,
        opReg32  = 7'b0111011
    } opcodeT;

    typedef enum logic [2:0] {
        lb  = 3'd0,
        lh  = 3'd1,
        lw  = 3'd2,
        ld  = 3'd3,
        lbu = 3'd4,
        lhu = 3'd5,
        lwu = 3'd6
    } loadFunctT;

    typedef enum logic [2:0] {
        sb = 3'd0,
        sh = 3'd1,
        sw = 3'd2,
        sd = 3'd3
    } storeFunctT;

    typedef enum logic [2:0] {
        beq  = 3'd0,
        bne  = 3'd1,
        blt  = 3'd4,
        bge  = 3'd5,
        bltu = 3'd6,
        bgeu = 3'd7
    } branchFunctT;

    // and/or/xor are keywords, hence the prefix
    typedef enum logic [2:0] {
        aluAdd  = 3'd0,
        aluSll  = 3'd1,
        aluSlt  = 3'd2,
        aluSltu = 3'd3,
        aluXor  = 3'd4,
        aluSrl  = 3'd5,
        aluOr   = 3'd6,
        aluAnd  = 3'd7
    } aluFunctT;

    typedef enum logic [2:0] {
        mul  = 3'd0,
        div  = 3'd4,
        divu = 3'd5,
        rem  = 3'd6,
        remu = 3'd7
    } muldivFunctT;

    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;  // sub, sra
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;  // M extension

endpackage
